// ==== Bender.yml ====
package:
  name: dma_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/dma_bus_pkg.sv
      - hw/dma_chan_pkg.sv
      - hw/dma_if.sv
      - hw/dma_bus_control.sv
      - hw/dma_address_count.sv
      - hw/dma_control_regs.sv
      - hw/dma_read_mux.sv
      - hw/dma_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/dma_chk.sv
      - sim/dma_tb.sv

// ==== hw/dma_address_count.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-channel address and word count
// Base/current registers loaded a byte at a
// time, the byte pointer, and the step engine
// with terminal count and autoinit reload.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_address_count (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 step,
    input  dma_chan_pkg::chan_t  step_channel,
    dma_reg_if.regs              regs,
    dma_chan_if.count            chan,
    output dma_chan_pkg::word_t  cur_address [`DMA_CHANNELS],
    output dma_chan_pkg::word_t  cur_count [`DMA_CHANNELS],
    output logic                 end_of_process
);
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;

    word_t base_address [`DMA_CHANNELS];
    word_t base_count [`DMA_CHANNELS];

    logic  wr_address, wr_count;
    logic  ptr_toggle, ptr_clear;
    logic  step_go, step_tc;
    word_t step_address;

    assign wr_address = regs.wr_strobe & (regs.sel == sel_address);
    assign wr_count   = regs.wr_strobe & (regs.sel == sel_count);
    assign ptr_toggle = (regs.wr_strobe | regs.rd_done) &
                        ((regs.sel == sel_address) | (regs.sel == sel_count));
    assign ptr_clear  = regs.wr_strobe &
                        ((regs.sel == sel_clear_ptr) | (regs.sel == sel_master_clear));

    // Step only an unmasked channel of an enabled controller
    assign step_go      = step & ~chan.mask[step_channel] & ~chan.ctrl_disable;
    assign step_tc      = (cur_count[step_channel] == '0);
    assign step_address = chan.decrement[step_channel] ? cur_address[step_channel] - 16'd1
                                                        : cur_address[step_channel] + 16'd1;

    always_ff @(posedge clock) begin
        if (reset) begin
            regs.byte_ptr  <= 1'b0;
            chan.tc_pulse  <= '0;
            end_of_process <= 1'b0;
            for (int c = 0; c < `DMA_CHANNELS; c++) begin
                base_address[c] <= '0;
                base_count[c]   <= '0;
                cur_address[c]  <= '0;
                cur_count[c]    <= '0;
            end
        end else begin
            chan.tc_pulse  <= '0;
            end_of_process <= |chan.tc_pulse;

            if (ptr_clear)
                regs.byte_ptr <= 1'b0;
            else if (ptr_toggle)
                regs.byte_ptr <= ~regs.byte_ptr;

            for (int c = 0; c < `DMA_CHANNELS; c++) begin
                if (wr_address && regs.chan == chan_t'(c)) begin
                    if (regs.byte_ptr) begin
                        base_address[c][15:8] <= regs.wr_data;
                        cur_address[c][15:8]  <= regs.wr_data;
                    end else begin
                        base_address[c][7:0] <= regs.wr_data;
                        cur_address[c][7:0]  <= regs.wr_data;
                    end
                end else if (wr_count && regs.chan == chan_t'(c)) begin
                    if (regs.byte_ptr) begin
                        base_count[c][15:8] <= regs.wr_data;
                        cur_count[c][15:8]  <= regs.wr_data;
                    end else begin
                        base_count[c][7:0] <= regs.wr_data;
                        cur_count[c][7:0]  <= regs.wr_data;
                    end
                end else if (step_go && step_channel == chan_t'(c)) begin
                    if (step_tc && chan.autoinit[c]) begin
                        cur_address[c] <= base_address[c];
                        cur_count[c]   <= base_count[c];
                    end else begin
                        cur_address[c] <= step_address;
                        cur_count[c]   <= cur_count[c] - 16'd1;
                    end
                    // Count wraps from 0 to FFFF at terminal count
                    chan.tc_pulse[c] <= step_tc;
                end
            end
        end
    end

endmodule

// ==== hw/dma_bus_control.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host port front end
// Samples the 8-bit port, finds the end of
// write and read strobes, and decodes the
// address into a register class and channel.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_bus_control (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    chip_select_n,
    input  logic                    io_read_n,
    input  logic                    io_write_n,
    input  dma_bus_pkg::port_addr_t address,
    input  dma_bus_pkg::data_byte_t data_in,
    dma_reg_if.bus                  regs
);
    import dma_bus_pkg::*;

    logic       write_n_q, write_n_q2;
    logic       read_n_q, read_n_q2;
    port_addr_t address_q;
    port_addr_t decode_address;

    // Strobe samples gated by chip select
    always_ff @(posedge clock) begin
        if (reset) begin
            write_n_q  <= 1'b1;
            write_n_q2 <= 1'b1;
            read_n_q   <= 1'b1;
            read_n_q2  <= 1'b1;
        end else begin
            write_n_q  <= io_write_n | chip_select_n;
            write_n_q2 <= write_n_q;
            read_n_q   <= io_read_n | chip_select_n;
            read_n_q2  <= read_n_q;
        end
    end

    // Hold address and data of the access in progress
    always_ff @(posedge clock) begin
        if (~chip_select_n & (~io_read_n | ~io_write_n))
            address_q <= address;
        if (~chip_select_n & ~io_write_n)
            regs.wr_data <= data_in;
    end

    assign regs.wr_strobe = ~write_n_q2 & write_n_q;
    assign regs.rd_done   = ~read_n_q2 & read_n_q;
    assign regs.rd_active = ~chip_select_n & ~io_read_n;

    // Live address during a read, the held one for the end-of-access pulses
    assign decode_address = regs.rd_active ? address : address_q;
    assign regs.chan      = decode_address[2:1];

    always_comb begin
        regs.sel = sel_none;
        if (regs.rd_active | regs.wr_strobe | regs.rd_done) begin
            if (~decode_address[3])
                regs.sel = decode_address[0] ? sel_count : sel_address;
            else begin
                case (decode_address)
                    `DMA_ADDR_CMD_STATUS:   regs.sel = sel_cmd_status;
                    `DMA_ADDR_REQUEST:      regs.sel = sel_request;
                    `DMA_ADDR_SINGLE_MASK:  regs.sel = sel_single_mask;
                    `DMA_ADDR_MODE:         regs.sel = sel_mode;
                    `DMA_ADDR_CLEAR_PTR:    regs.sel = sel_clear_ptr;
                    `DMA_ADDR_MASTER_CLEAR: regs.sel = sel_master_clear;
                    `DMA_ADDR_CLEAR_MASK:   regs.sel = sel_clear_mask;
                    `DMA_ADDR_ALL_MASK:     regs.sel = sel_all_mask;
                    default:                regs.sel = sel_none;
                endcase
            end
        end
    end

endmodule

// ==== hw/dma_bus_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host port types for the DMA controller
// Data byte, port address and the decoded
// register class shared by the port blocks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dma_bus_pkg;

    typedef logic [7:0] data_byte_t;
    typedef logic [3:0] port_addr_t;

    // Register class addressed by the host
    typedef enum logic [3:0] {
        sel_none,
        sel_address,
        sel_count,
        sel_cmd_status,
        sel_request,
        sel_single_mask,
        sel_mode,
        sel_clear_ptr,
        sel_master_clear,
        sel_clear_mask,
        sel_all_mask
    } reg_sel_t;

endpackage

// ==== hw/dma_chan_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Channel state types for the DMA controller
// Address/count words, channel index and the
// one-bit-per-channel vector.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dma_defines.svh"

package dma_chan_pkg;

    // Address or word count
    typedef logic [15:0] word_t;

    typedef logic [$clog2(`DMA_CHANNELS)-1:0] chan_t;

    // One bit per channel (mask, TC, mode bits)
    typedef logic [`DMA_CHANNELS-1:0] chan_vec_t;

endpackage

// ==== hw/dma_control_regs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command, mode, request, mask and status
// Handles the register writes and software
// commands, latches TC flags for status.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dma_control_regs (
    input  logic                    clock,
    input  logic                    reset,
    dma_reg_if.regs                 regs,
    dma_chan_if.ctrl                chan,
    output dma_bus_pkg::data_byte_t status
);
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;

    chan_vec_t request;
    chan_vec_t tc_flags;
    chan_vec_t mask_next;
    chan_t     data_chan;
    logic      master_clear;
    logic      status_clear;

    assign data_chan    = regs.wr_data[1:0];
    assign master_clear = regs.wr_strobe & (regs.sel == sel_master_clear);
    assign status_clear = regs.rd_done & (regs.sel == sel_cmd_status);

    always_comb begin
        mask_next = chan.mask;
        if (regs.wr_strobe) begin
            case (regs.sel)
                sel_single_mask:  mask_next[data_chan] = regs.wr_data[2];
                sel_all_mask:     mask_next = regs.wr_data[3:0];
                sel_clear_mask:   mask_next = '0;
                sel_master_clear: mask_next = '1;
                default:          mask_next = chan.mask;
            endcase
        end
        // A finished channel without autoinit masks itself
        mask_next = mask_next | (chan.tc_pulse & ~chan.autoinit);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            chan.mask         <= '1;
            chan.autoinit     <= '0;
            chan.decrement    <= '0;
            chan.ctrl_disable <= 1'b0;
            request           <= '0;
            tc_flags          <= '0;
        end else begin
            chan.mask <= mask_next;
            if (master_clear) begin
                chan.ctrl_disable <= 1'b0;
                request           <= '0;
                tc_flags          <= '0;
            end else begin
                tc_flags <= (status_clear ? '0 : tc_flags) | chan.tc_pulse;
                if (regs.wr_strobe && regs.sel == sel_cmd_status)
                    chan.ctrl_disable <= regs.wr_data[2];
                if (regs.wr_strobe && regs.sel == sel_request)
                    request[data_chan] <= regs.wr_data[2];
                if (regs.wr_strobe && regs.sel == sel_mode) begin
                    chan.decrement[data_chan] <= regs.wr_data[5];
                    chan.autoinit[data_chan]  <= regs.wr_data[4];
                end
            end
        end
    end

    assign status = {request, tc_flags};

endmodule

// ==== hw/dma_core.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-channel DMA controller core
// Top level with the host port and the step
// input; ties the port, register and engine
// blocks together.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_core (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    chip_select_n,
    input  logic                    io_read_n,
    input  logic                    io_write_n,
    input  dma_bus_pkg::port_addr_t address,
    input  dma_bus_pkg::data_byte_t data_in,
    input  logic                    step,
    input  dma_chan_pkg::chan_t     step_channel,
    output dma_bus_pkg::data_byte_t data_out,
    output logic                    end_of_process
);
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;

    word_t      cur_address [`DMA_CHANNELS];
    word_t      cur_count [`DMA_CHANNELS];
    data_byte_t status;

    dma_reg_if  reg_bus ();
    dma_chan_if chan_bus ();

    dma_bus_control bus_control_i (
        .clock         (clock),
        .reset         (reset),
        .chip_select_n (chip_select_n),
        .io_read_n     (io_read_n),
        .io_write_n    (io_write_n),
        .address       (address),
        .data_in       (data_in),
        .regs          (reg_bus.bus)
    );

    dma_address_count address_count_i (
        .clock          (clock),
        .reset          (reset),
        .step           (step),
        .step_channel   (step_channel),
        .regs           (reg_bus.regs),
        .chan           (chan_bus.count),
        .cur_address    (cur_address),
        .cur_count      (cur_count),
        .end_of_process (end_of_process)
    );

    dma_control_regs control_regs_i (
        .clock  (clock),
        .reset  (reset),
        .regs   (reg_bus.regs),
        .chan   (chan_bus.ctrl),
        .status (status)
    );

    dma_read_mux read_mux_i (
        .regs        (reg_bus.reader),
        .cur_address (cur_address),
        .cur_count   (cur_count),
        .status      (status),
        .data_out    (data_out)
    );

endmodule

// ==== hw/dma_defines.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA controller parameters
// Channel count and the 4-bit port addresses
// of the control registers and commands.
// Include wherever these values are needed.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

`define DMA_CHANNELS 4

// Addresses 0..7 interleave address and count per channel
`define DMA_ADDR_CMD_STATUS   4'd8
`define DMA_ADDR_REQUEST      4'd9
`define DMA_ADDR_SINGLE_MASK  4'd10
`define DMA_ADDR_MODE         4'd11

// Software commands
`define DMA_ADDR_CLEAR_PTR    4'd12
`define DMA_ADDR_MASTER_CLEAR 4'd13
`define DMA_ADDR_CLEAR_MASK   4'd14
`define DMA_ADDR_ALL_MASK     4'd15

`endif

// ==== hw/dma_if.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal interfaces of the DMA core
// dma_reg_if carries decoded host accesses,
// dma_chan_if the per-channel control/TC path.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface dma_reg_if;
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;

    logic       wr_strobe;
    logic       rd_active;
    logic       rd_done;
    reg_sel_t   sel;
    chan_t      chan;
    data_byte_t wr_data;
    // Driven back by the address/count block
    logic       byte_ptr;

    modport bus (
        output wr_strobe, rd_active, rd_done, sel, chan, wr_data
    );

    modport regs (
        input  wr_strobe, rd_active, rd_done, sel, chan, wr_data,
        output byte_ptr
    );

    modport reader (
        input sel, chan, byte_ptr, rd_active
    );
endinterface

interface dma_chan_if;
    import dma_chan_pkg::*;

    chan_vec_t mask;
    chan_vec_t autoinit;
    chan_vec_t decrement;
    logic      ctrl_disable;
    chan_vec_t tc_pulse;

    modport ctrl (
        output mask, autoinit, decrement, ctrl_disable,
        input  tc_pulse
    );

    modport count (
        input  mask, autoinit, decrement, ctrl_disable,
        output tc_pulse
    );
endinterface

// ==== hw/dma_read_mux.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read data selection
// Drives the addressed byte onto data_out
// while a read is active, 0 otherwise.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_read_mux (
    dma_reg_if.reader               regs,
    input  dma_chan_pkg::word_t     cur_address [`DMA_CHANNELS],
    input  dma_chan_pkg::word_t     cur_count [`DMA_CHANNELS],
    input  dma_bus_pkg::data_byte_t status,
    output dma_bus_pkg::data_byte_t data_out
);
    import dma_bus_pkg::*;

    always_comb begin
        data_out = '0;
        if (regs.rd_active) begin
            case (regs.sel)
                sel_address:
                    data_out = regs.byte_ptr ? cur_address[regs.chan][15:8]
                                             : cur_address[regs.chan][7:0];
                sel_count:
                    data_out = regs.byte_ptr ? cur_count[regs.chan][15:8]
                                             : cur_count[regs.chan][7:0];
                sel_cmd_status:
                    data_out = status;
                default:
                    data_out = '0;
            endcase
        end
    end

endmodule

// ==== sim.f ====
+incdir+hw
hw/dma_bus_pkg.sv
hw/dma_chan_pkg.sv
hw/dma_if.sv
hw/dma_bus_control.sv
hw/dma_address_count.sv
hw/dma_control_regs.sv
hw/dma_read_mux.sv
hw/dma_core.sv
sim/dma_chk.sv
sim/dma_tb.sv

// ==== sim/dma_chk.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions for the DMA core
// Bound into dma_core; watches the write strobe,
// end_of_process timing and idle read data.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dma_chk (
    input logic                    clock,
    input logic                    reset,
    input logic                    io_read_n,
    input dma_bus_pkg::data_byte_t data_out,
    input logic                    end_of_process,
    input logic                    wr_strobe,
    input dma_chan_pkg::chan_vec_t tc_pulse
);
    int failures = 0;

    // Write strobe is a single-cycle pulse
    assert property (@(posedge clock) disable iff (reset) wr_strobe |=> !wr_strobe)
        else begin
            failures++;
            $error("Write strobe stayed high for two cycles");
        end

    assert property (@(posedge clock) disable iff (reset) (|tc_pulse) |=> end_of_process)
        else begin
            failures++;
            $error("end_of_process did not follow a terminal count pulse");
        end

    assert property (@(posedge clock) disable iff (reset) !(|tc_pulse) |=> !end_of_process)
        else begin
            failures++;
            $error("end_of_process rose without a terminal count pulse");
        end

    // Idle port reads as zero
    assert property (@(posedge clock) disable iff (reset) io_read_n |-> data_out == '0)
        else begin
            failures++;
            $error("Read data was not zero while no read was active");
        end

endmodule

bind dma_core dma_chk chk_i (
    .clock          (clock),
    .reset          (reset),
    .io_read_n      (io_read_n),
    .data_out       (data_out),
    .end_of_process (end_of_process),
    .wr_strobe      (reg_bus.wr_strobe),
    .tc_pulse       (chan_bus.tc_pulse)
);

// ==== sim/dma_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the DMA controller core
// Builds a stimulus table from a reference model,
// applies it through the host port and step input,
// and prints one result line at the end.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_tb;
    import dma_bus_pkg::*;
    import dma_chan_pkg::*;

    typedef enum logic [1:0] {op_write, op_read, op_step} op_t;

    // Step entries carry the channel in addr and end_of_process in expected[0]
    typedef struct packed {
        op_t        op;
        port_addr_t addr;
        data_byte_t data;
        data_byte_t expected;
    } entry_t;

    logic       clock = 1'b0;
    logic       reset;
    logic       chip_select_n;
    logic       io_read_n;
    logic       io_write_n;
    port_addr_t address;
    data_byte_t data_in;
    logic       step;
    chan_t      step_channel;
    data_byte_t data_out;
    logic       end_of_process;

    entry_t table_q[$];
    logic   table_ready = 1'b0;
    integer seed = 26527;
    int     checks = 0;
    int     errors = 0;

    // Reference model state
    word_t     m_base_addr [`DMA_CHANNELS];
    word_t     m_base_cnt [`DMA_CHANNELS];
    word_t     m_cur_addr [`DMA_CHANNELS];
    word_t     m_cur_cnt [`DMA_CHANNELS];
    chan_vec_t m_mask;
    chan_vec_t m_autoinit;
    chan_vec_t m_decrement;
    chan_vec_t m_request;
    chan_vec_t m_tc;
    logic      m_disable;
    logic      m_ptr;

    dma_core dma_core_i (
        .clock          (clock),
        .reset          (reset),
        .chip_select_n  (chip_select_n),
        .io_read_n      (io_read_n),
        .io_write_n     (io_write_n),
        .address        (address),
        .data_in        (data_in),
        .step           (step),
        .step_channel   (step_channel),
        .data_out       (data_out),
        .end_of_process (end_of_process)
    );

    always #2 clock = ~clock;

    function automatic void add_entry(input op_t op, input port_addr_t addr,
                                      input data_byte_t data, input data_byte_t expected);
        entry_t e;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.expected = expected;
        table_q.push_back(e);
    endfunction

    function automatic word_t put_byte(input word_t w, input logic high, input data_byte_t d);
        word_t r;
        r = w;
        if (high)
            r[15:8] = d;
        else
            r[7:0] = d;
        return r;
    endfunction

    function automatic void push_write(input port_addr_t addr, input data_byte_t data);
        chan_t ch;
        ch = addr[2:1];
        if (!addr[3]) begin
            if (addr[0]) begin
                m_base_cnt[ch] = put_byte(m_base_cnt[ch], m_ptr, data);
                m_cur_cnt[ch]  = put_byte(m_cur_cnt[ch], m_ptr, data);
            end else begin
                m_base_addr[ch] = put_byte(m_base_addr[ch], m_ptr, data);
                m_cur_addr[ch]  = put_byte(m_cur_addr[ch], m_ptr, data);
            end
            m_ptr = ~m_ptr;
        end else begin
            case (addr)
                `DMA_ADDR_CMD_STATUS:  m_disable = data[2];
                `DMA_ADDR_REQUEST:     m_request[data[1:0]] = data[2];
                `DMA_ADDR_SINGLE_MASK: m_mask[data[1:0]] = data[2];
                `DMA_ADDR_MODE: begin
                    m_decrement[data[1:0]] = data[5];
                    m_autoinit[data[1:0]]  = data[4];
                end
                `DMA_ADDR_CLEAR_PTR:   m_ptr = 1'b0;
                `DMA_ADDR_MASTER_CLEAR: begin
                    m_ptr     = 1'b0;
                    m_mask    = '1;
                    m_disable = 1'b0;
                    m_request = '0;
                    m_tc      = '0;
                end
                `DMA_ADDR_CLEAR_MASK:  m_mask = '0;
                default:               m_mask = data[3:0];
            endcase
        end
        add_entry(op_write, addr, data, 8'h00);
    endfunction

    function automatic void expect_read(input port_addr_t addr);
        word_t      w;
        data_byte_t value;
        value = 8'h00;
        if (!addr[3]) begin
            w     = addr[0] ? m_cur_cnt[addr[2:1]] : m_cur_addr[addr[2:1]];
            value = m_ptr ? w[15:8] : w[7:0];
            m_ptr = ~m_ptr;
        end else if (addr == `DMA_ADDR_CMD_STATUS) begin
            value = {m_request, m_tc};
            m_tc  = '0;
        end
        add_entry(op_read, addr, 8'h00, value);
    endfunction

    function automatic void predict_step(input chan_t ch);
        logic tc;
        tc = 1'b0;
        if (!m_mask[ch] && !m_disable) begin
            tc = (m_cur_cnt[ch] == 16'h0000);
            if (tc && m_autoinit[ch]) begin
                m_cur_addr[ch] = m_base_addr[ch];
                m_cur_cnt[ch]  = m_base_cnt[ch];
            end else begin
                m_cur_addr[ch] = m_decrement[ch] ? m_cur_addr[ch] - 16'd1
                                                 : m_cur_addr[ch] + 16'd1;
                m_cur_cnt[ch]  = m_cur_cnt[ch] - 16'd1;
            end
            if (tc) begin
                m_tc[ch] = 1'b1;
                if (!m_autoinit[ch])
                    m_mask[ch] = 1'b1;
            end
        end
        add_entry(op_step, port_addr_t'(ch), 8'h00, {7'd0, tc});
    endfunction

    // Pointer cleared, then both bytes of address and count
    function automatic void read_channel(input int ch);
        push_write(`DMA_ADDR_CLEAR_PTR, 8'h00);
        expect_read(port_addr_t'(2 * ch));
        expect_read(port_addr_t'(2 * ch));
        expect_read(port_addr_t'(2 * ch + 1));
        expect_read(port_addr_t'(2 * ch + 1));
    endfunction

    task automatic build_table();
        word_t value;
        for (int c = 0; c < `DMA_CHANNELS; c++) begin
            m_base_addr[c] = '0;
            m_base_cnt[c]  = '0;
            m_cur_addr[c]  = '0;
            m_cur_cnt[c]   = '0;
        end
        m_mask      = '1;
        m_autoinit  = '0;
        m_decrement = '0;
        m_request   = '0;
        m_tc        = '0;
        m_disable   = 1'b0;
        m_ptr       = 1'b0;

        // Random address and count for every channel, low byte first
        push_write(`DMA_ADDR_CLEAR_PTR, 8'h00);
        for (int c = 0; c < `DMA_CHANNELS; c++) begin
            for (int r = 0; r < 2; r++) begin
                value = word_t'($random(seed));
                push_write(port_addr_t'(2 * c + r), value[7:0]);
                push_write(port_addr_t'(2 * c + r), value[15:8]);
            end
        end
        for (int c = 0; c < `DMA_CHANNELS; c++) begin
            for (int r = 0; r < 4; r++)
                expect_read(port_addr_t'(2 * c + r / 2));
        end

        // Clear pointer between the two bytes
        value = word_t'($random(seed));
        push_write(4'd0, value[7:0]);
        push_write(`DMA_ADDR_CLEAR_PTR, 8'h00);
        value = word_t'($random(seed));
        push_write(4'd0, value[7:0]);
        push_write(4'd0, value[15:8]);
        expect_read(4'd0);
        expect_read(4'd0);

        // Channel 1 counts down from 2 with decrement, no autoinit
        push_write(4'd3, 8'h02);
        push_write(4'd3, 8'h00);
        push_write(`DMA_ADDR_MODE, 8'h21);
        push_write(`DMA_ADDR_SINGLE_MASK, 8'h01);
        repeat (3) predict_step(2'd1);
        expect_read(`DMA_ADDR_CMD_STATUS);
        expect_read(`DMA_ADDR_CMD_STATUS);
        predict_step(2'd1);
        read_channel(1);

        // Channel 2 with autoinit reloads its base values
        push_write(4'd5, 8'h01);
        push_write(4'd5, 8'h00);
        push_write(`DMA_ADDR_MODE, 8'h12);
        push_write(`DMA_ADDR_SINGLE_MASK, 8'h02);
        repeat (2) predict_step(2'd2);
        read_channel(2);
        expect_read(`DMA_ADDR_CMD_STATUS);
        predict_step(2'd2);
        read_channel(2);

        // Requests, masks and controller disable
        push_write(`DMA_ADDR_REQUEST, 8'h07);
        push_write(`DMA_ADDR_REQUEST, 8'h04);
        expect_read(`DMA_ADDR_CMD_STATUS);
        push_write(`DMA_ADDR_REQUEST, 8'h03);
        expect_read(`DMA_ADDR_CMD_STATUS);
        push_write(`DMA_ADDR_CLEAR_MASK, 8'h00);
        predict_step(2'd0);
        push_write(`DMA_ADDR_ALL_MASK, 8'h01);
        predict_step(2'd0);
        predict_step(2'd3);
        push_write(`DMA_ADDR_CMD_STATUS, 8'h04);
        predict_step(2'd3);
        push_write(`DMA_ADDR_CMD_STATUS, 8'h00);
        predict_step(2'd3);
        read_channel(0);
        read_channel(3);

        // Master clear with the pointer left on the high byte
        expect_read(4'd6);
        push_write(`DMA_ADDR_MASTER_CLEAR, 8'h00);
        expect_read(`DMA_ADDR_CMD_STATUS);
        for (int c = 0; c < `DMA_CHANNELS; c++)
            predict_step(chan_t'(c));
        for (int c = 0; c < `DMA_CHANNELS; c++) begin
            expect_read(port_addr_t'(2 * c));
            expect_read(port_addr_t'(2 * c));
        end
    endtask

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s gave %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic port_write(input port_addr_t addr, input data_byte_t data);
        @(posedge clock);
        chip_select_n <= 1'b0;
        io_write_n    <= 1'b0;
        address       <= addr;
        data_in       <= data;
        repeat (2) @(posedge clock);
        chip_select_n <= 1'b1;
        io_write_n    <= 1'b1;
        repeat (3) @(posedge clock);
    endtask

    task automatic read_and_compare(input port_addr_t addr, input data_byte_t expected);
        @(posedge clock);
        chip_select_n <= 1'b0;
        io_read_n     <= 1'b0;
        address       <= addr;
        @(posedge clock);
        @(negedge clock);
        check_value(data_out, expected, $sformatf("read of port address %0d", addr));
        @(posedge clock);
        chip_select_n <= 1'b1;
        io_read_n     <= 1'b1;
        repeat (3) @(posedge clock);
    endtask

    task automatic pulse_step(input chan_t ch, input logic expected);
        @(posedge clock);
        step         <= 1'b1;
        step_channel <= ch;
        @(posedge clock);
        step <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_value(end_of_process, expected,
                    $sformatf("end_of_process after step on channel %0d", ch));
        repeat (2) @(posedge clock);
    endtask

    initial begin
        reset         = 1'b1;
        chip_select_n = 1'b1;
        io_read_n     = 1'b1;
        io_write_n    = 1'b1;
        address       = '0;
        data_in       = '0;
        step          = 1'b0;
        step_channel  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);

        foreach (table_q[i]) begin
            case (table_q[i].op)
                op_write: port_write(table_q[i].addr, table_q[i].data);
                op_read:  read_and_compare(table_q[i].addr, table_q[i].expected);
                default:  pulse_step(table_q[i].addr[1:0], table_q[i].expected[0]);
            endcase
        end
        repeat (4) @(posedge clock);

        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, dma_core_i.chk_i.failures);
        if (errors == 0 && dma_core_i.chk_i.failures == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog of ten cycles per table entry plus a margin
    initial begin
        wait (table_ready);
        repeat (table_q.size() * 10 + 200) @(posedge clock);
        $display("Run timed out before the stimulus table was finished");
        $display("Done: errors found");
        $finish;
    end

endmodule
